// ==== src/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // Major opcodes handled by the core, anything else runs as a no-op
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [1:0] {
    FETCH     = 2'd0,
    EXECUTE   = 2'd1,
    MEMORY    = 2'd2,
    WRITEBACK = 2'd3
  } ctrl_state_e;

  // funct3 for OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA, told apart by bit 30
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t; // One bit per byte lane, zero means read

  // Same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } access_size_e;

endpackage

`default_nettype wire

// ==== src/mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_if;

  logic valid;
  logic instr;
  mem_pkg::addr_t addr;
  mem_pkg::data_t wdata;
  mem_pkg::strb_t wstrb;
  mem_pkg::data_t rdata;
  logic ready;

  modport requester (
    output valid,
    output instr,
    output addr,
    output wdata,
    output wstrb,
    input rdata,
    input ready
  );

  modport responder (
    input valid,
    input instr,
    input addr,
    input wdata,
    input wstrb,
    output rdata,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter riscv_pkg::word_t reset_vector = 32'h0000_0000
) (
  input logic clk,
  input logic rst_n,
  input logic fetch,
  input logic pc_load,
  input riscv_pkg::word_t next_pc,
  output riscv_pkg::word_t pc,
  output riscv_pkg::word_t instr_word,
  output logic fetch_done,
  mem_if.requester ibus
);

  logic req_valid;
  logic accepted;

  assign accepted = req_valid && ibus.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_vector;
      req_valid <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= accepted;
      if (pc_load) begin
        pc <= next_pc;
      end
      if (fetch) begin
        req_valid <= 1'b1;
      end else if (accepted) begin
        req_valid <= 1'b0; // Drop valid the cycle after ready
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accepted) begin
      instr_word <= ibus.rdata;
    end
  end

  // Read-only port, address comes straight from the PC
  assign ibus.valid = req_valid;
  assign ibus.instr = 1'b1;
  assign ibus.addr = pc;
  assign ibus.wdata = '0;
  assign ibus.wstrb = '0;

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input logic clk,
  input logic rst_n,
  input riscv_pkg::word_t instr_word,
  input riscv_pkg::word_t pc,
  input logic fetch_done,
  output logic fetch,
  output logic pc_load,
  output riscv_pkg::word_t next_pc,
  output riscv_pkg::reg_idx_t rs1_idx,
  output riscv_pkg::reg_idx_t rs2_idx,
  input riscv_pkg::word_t rs1_val,
  input riscv_pkg::word_t rs2_val,
  output logic rd_we,
  output riscv_pkg::reg_idx_t rd_idx,
  output riscv_pkg::word_t rd_val,
  output logic mem_start,
  output riscv_pkg::word_t mem_addr,
  output riscv_pkg::word_t mem_wdata,
  output mem_pkg::access_size_e mem_size,
  output logic mem_store,
  output logic mem_unsigned,
  input logic mem_done,
  input riscv_pkg::word_t load_val
);

  riscv_pkg::ctrl_state_e state;
  riscv_pkg::opcode_e opcode;
  logic [2:0] funct3;
  logic sub;
  logic taken;
  logic is_mem;
  logic writes_rd;
  logic fetch_q;
  riscv_pkg::word_t imm_i;
  riscv_pkg::word_t imm_s;
  riscv_pkg::word_t imm_b;
  riscv_pkg::word_t imm_u;
  riscv_pkg::word_t imm_j;
  riscv_pkg::word_t op_b;
  riscv_pkg::word_t alu_res;
  riscv_pkg::word_t result;
  riscv_pkg::word_t target;
  riscv_pkg::word_t result_q;
  riscv_pkg::word_t next_pc_q;

  assign opcode = riscv_pkg::opcode_e'(instr_word[6:0]);
  assign funct3 = instr_word[14:12];
  assign sub = (opcode == riscv_pkg::OP) && instr_word[30];

  assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
  assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
  assign imm_b = {{19{instr_word[31]}}, instr_word[31], instr_word[7],
                  instr_word[30:25], instr_word[11:8], 1'b0};
  assign imm_u = {instr_word[31:12], 12'h000};
  assign imm_j = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
                  instr_word[20], instr_word[30:21], 1'b0};

  assign op_b = (opcode == riscv_pkg::OP) ? rs2_val : imm_i;

  always_comb begin
    case (funct3)
      riscv_pkg::F3_ADD: alu_res = sub ? rs1_val - op_b : rs1_val + op_b;
      riscv_pkg::F3_SLL: alu_res = rs1_val << op_b[4:0];
      riscv_pkg::F3_SLT: alu_res = {31'd0, $signed(rs1_val) < $signed(op_b)};
      riscv_pkg::F3_SLTU: alu_res = {31'd0, rs1_val < op_b};
      riscv_pkg::F3_XOR: alu_res = rs1_val ^ op_b;
      riscv_pkg::F3_SR: begin
        if (instr_word[30]) begin
          alu_res = $signed(rs1_val) >>> op_b[4:0]; // Arithmetic shift
        end else begin
          alu_res = rs1_val >> op_b[4:0];
        end
      end
      riscv_pkg::F3_OR: alu_res = rs1_val | op_b;
      riscv_pkg::F3_AND: alu_res = rs1_val & op_b;
    endcase
  end

  always_comb begin
    case (funct3)
      riscv_pkg::F3_BEQ: taken = rs1_val == rs2_val;
      riscv_pkg::F3_BNE: taken = rs1_val != rs2_val;
      riscv_pkg::F3_BLT: taken = $signed(rs1_val) < $signed(rs2_val);
      riscv_pkg::F3_BGE: taken = $signed(rs1_val) >= $signed(rs2_val);
      riscv_pkg::F3_BLTU: taken = rs1_val < rs2_val;
      riscv_pkg::F3_BGEU: taken = rs1_val >= rs2_val;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    result = alu_res;
    target = pc + 32'd4;
    writes_rd = 1'b1;
    is_mem = 1'b0;
    case (opcode)
      riscv_pkg::LUI: result = imm_u;
      riscv_pkg::AUIPC: result = pc + imm_u;
      riscv_pkg::JAL: begin
        result = pc + 32'd4; // Link value
        target = pc + imm_j;
      end
      riscv_pkg::JALR: begin
        result = pc + 32'd4;
        target = (rs1_val + imm_i) & ~32'd1;
      end
      riscv_pkg::BRANCH: begin
        writes_rd = 1'b0;
        if (taken) begin
          target = pc + imm_b;
        end
      end
      riscv_pkg::LOAD: is_mem = 1'b1;
      riscv_pkg::STORE: begin
        writes_rd = 1'b0;
        is_mem = 1'b1;
      end
      riscv_pkg::OP_IMM, riscv_pkg::OP: result = alu_res;
      default: writes_rd = 1'b0; // Unknown opcode falls through as a no-op
    endcase
  end

  always_comb begin
    case (funct3[1:0])
      2'b00: mem_size = mem_pkg::BYTE;
      2'b01: mem_size = mem_pkg::HALF;
      default: mem_size = mem_pkg::WORD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= riscv_pkg::FETCH;
      fetch_q <= 1'b1; // First fetch right after reset
    end else begin
      fetch_q <= (state == riscv_pkg::WRITEBACK);
      case (state)
        riscv_pkg::FETCH: begin
          if (fetch_done) begin
            state <= riscv_pkg::EXECUTE;
          end
        end
        riscv_pkg::EXECUTE: state <= is_mem ? riscv_pkg::MEMORY : riscv_pkg::WRITEBACK;
        riscv_pkg::MEMORY: begin
          if (mem_done) begin
            state <= riscv_pkg::WRITEBACK;
          end
        end
        default: state <= riscv_pkg::FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == riscv_pkg::EXECUTE) begin
      result_q <= result;
      next_pc_q <= target;
    end
  end

  assign fetch = fetch_q;
  assign pc_load = (state == riscv_pkg::WRITEBACK);
  assign next_pc = next_pc_q;

  assign rs1_idx = instr_word[19:15];
  assign rs2_idx = instr_word[24:20];
  assign rd_idx = instr_word[11:7];
  assign rd_we = (state == riscv_pkg::WRITEBACK) && writes_rd;
  assign rd_val = (opcode == riscv_pkg::LOAD) ? load_val : result_q;

  assign mem_start = (state == riscv_pkg::EXECUTE) && is_mem;
  assign mem_store = (opcode == riscv_pkg::STORE);
  assign mem_addr = rs1_val + (mem_store ? imm_s : imm_i);
  assign mem_wdata = rs2_val;
  assign mem_unsigned = funct3[2];

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input logic clk,
  input riscv_pkg::reg_idx_t rs1_idx,
  input riscv_pkg::reg_idx_t rs2_idx,
  output riscv_pkg::word_t rs1_val,
  output riscv_pkg::word_t rs2_val,
  input logic rd_we,
  input riscv_pkg::reg_idx_t rd_idx,
  input riscv_pkg::word_t rd_val
);

  // x0 has no storage
  riscv_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rd_we && (rd_idx != 5'd0)) begin
      regs[rd_idx] <= rd_val;
    end
  end

  assign rs1_val = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// ==== src/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic store,
  input logic is_unsigned,
  input riscv_pkg::word_t addr,
  input riscv_pkg::word_t wdata,
  input mem_pkg::access_size_e size,
  output logic done,
  output riscv_pkg::word_t load_val,
  mem_if.requester dbus
);

  logic req_valid;
  logic accepted;
  logic req_unsigned;
  logic [1:0] offset;
  mem_pkg::access_size_e req_size;
  mem_pkg::addr_t req_addr;
  mem_pkg::data_t req_wdata;
  mem_pkg::strb_t req_strb;
  mem_pkg::strb_t strb;
  mem_pkg::data_t wdata_rep;
  mem_pkg::data_t shifted;
  riscv_pkg::word_t aligned;

  always_comb begin
    case (size)
      mem_pkg::BYTE: begin
        strb = 4'b0001 << addr[1:0];
        wdata_rep = {4{wdata[7:0]}};
      end
      mem_pkg::HALF: begin
        strb = 4'b0011 << {addr[1], 1'b0};
        wdata_rep = {2{wdata[15:0]}};
      end
      default: begin
        strb = 4'b1111;
        wdata_rep = wdata;
      end
    endcase
  end

  assign accepted = req_valid && dbus.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= accepted;
      if (start) begin
        req_valid <= 1'b1;
      end else if (accepted) begin
        req_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_addr <= {addr[31:2], 2'b00};
      req_wdata <= wdata_rep;
      req_strb <= store ? strb : 4'b0000;
      offset <= addr[1:0];
      req_size <= size;
      req_unsigned <= is_unsigned;
    end
    if (accepted) begin
      load_val <= aligned;
    end
  end

  // Bring the addressed lane down to bit 0, then extend
  assign shifted = dbus.rdata >> {offset, 3'b000};

  always_comb begin
    case (req_size)
      mem_pkg::BYTE: aligned = {{24{shifted[7] & ~req_unsigned}}, shifted[7:0]};
      mem_pkg::HALF: aligned = {{16{shifted[15] & ~req_unsigned}}, shifted[15:0]};
      default: aligned = shifted;
    endcase
  end

  assign dbus.valid = req_valid;
  assign dbus.instr = 1'b0;
  assign dbus.addr = req_addr;
  assign dbus.wdata = req_wdata;
  assign dbus.wstrb = req_strb;

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter riscv_pkg::word_t reset_vector = 32'h0000_0000
) (
  input logic clk,
  input logic rst_n,
  output logic imemory_valid,
  output logic imemory_instr,
  output mem_pkg::addr_t imemory_addr,
  output mem_pkg::data_t imemory_wdata,
  output mem_pkg::strb_t imemory_wstrb,
  input mem_pkg::data_t imemory_rdata,
  input logic imemory_ready,
  output logic dmemory_valid,
  output logic dmemory_instr,
  output mem_pkg::addr_t dmemory_addr,
  output mem_pkg::data_t dmemory_wdata,
  output mem_pkg::strb_t dmemory_wstrb,
  input mem_pkg::data_t dmemory_rdata,
  input logic dmemory_ready
);

  logic fetch;
  logic pc_load;
  logic fetch_done;
  riscv_pkg::word_t next_pc;
  riscv_pkg::word_t pc;
  riscv_pkg::word_t instr_word;
  riscv_pkg::reg_idx_t rs1_idx;
  riscv_pkg::reg_idx_t rs2_idx;
  riscv_pkg::reg_idx_t rd_idx;
  riscv_pkg::word_t rs1_val;
  riscv_pkg::word_t rs2_val;
  riscv_pkg::word_t rd_val;
  logic rd_we;
  logic mem_start;
  logic mem_store;
  logic mem_unsigned;
  logic mem_done;
  riscv_pkg::word_t mem_addr;
  riscv_pkg::word_t mem_wdata;
  riscv_pkg::word_t load_val;
  mem_pkg::access_size_e mem_size;

  mem_if ibus ();
  mem_if dbus ();

  fetch_unit #(
    .reset_vector (reset_vector)
  ) fetch_unit0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch      (fetch),
    .pc_load    (pc_load),
    .next_pc    (next_pc),
    .pc         (pc),
    .instr_word (instr_word),
    .fetch_done (fetch_done),
    .ibus       (ibus.requester)
  );

  execute_unit execute_unit0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_word   (instr_word),
    .pc           (pc),
    .fetch_done   (fetch_done),
    .fetch        (fetch),
    .pc_load      (pc_load),
    .next_pc      (next_pc),
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .rs1_val      (rs1_val),
    .rs2_val      (rs2_val),
    .rd_we        (rd_we),
    .rd_idx       (rd_idx),
    .rd_val       (rd_val),
    .mem_start    (mem_start),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_size     (mem_size),
    .mem_store    (mem_store),
    .mem_unsigned (mem_unsigned),
    .mem_done     (mem_done),
    .load_val     (load_val)
  );

  register_file register_file0 (
    .clk     (clk),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .rd_we   (rd_we),
    .rd_idx  (rd_idx),
    .rd_val  (rd_val)
  );

  lsu lsu0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (mem_start),
    .store       (mem_store),
    .is_unsigned (mem_unsigned),
    .addr        (mem_addr),
    .wdata       (mem_wdata),
    .size        (mem_size),
    .done        (mem_done),
    .load_val    (load_val),
    .dbus        (dbus.requester)
  );

  assign imemory_valid = ibus.valid;
  assign imemory_instr = ibus.instr;
  assign imemory_addr = ibus.addr;
  assign imemory_wdata = ibus.wdata;
  assign imemory_wstrb = ibus.wstrb;
  assign ibus.rdata = imemory_rdata;
  assign ibus.ready = imemory_ready;

  assign dmemory_valid = dbus.valid;
  assign dmemory_instr = dbus.instr;
  assign dmemory_addr = dbus.addr;
  assign dmemory_wdata = dbus.wdata;
  assign dmemory_wstrb = dbus.wstrb;
  assign dbus.rdata = dmemory_rdata;
  assign dbus.ready = dmemory_ready;

endmodule

`default_nettype wire

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input logic clk,
  input logic rst_n,
  input logic imemory_valid,
  input logic [31:0] imemory_addr,
  output logic [31:0] imemory_rdata,
  output logic imemory_ready,
  input logic dmemory_valid,
  input logic [31:0] dmemory_addr,
  input logic [31:0] dmemory_wdata,
  input logic [3:0] dmemory_wstrb,
  output logic [31:0] dmemory_rdata,
  output logic dmemory_ready
);

  localparam logic [6:0] OPC_IMM = 7'h13;
  localparam logic [6:0] OPC_OP = 7'h33;
  localparam logic [6:0] OPC_LUI = 7'h37;
  localparam logic [6:0] OPC_AUIPC = 7'h17;
  localparam logic [6:0] OPC_LOAD = 7'h03;
  localparam logic [6:0] OPC_JALR = 7'h67;

  logic [31:0] mem [0:1023];
  integer seed;
  integer i_wait;
  integer d_wait;
  integer i_cnt;
  integer d_cnt;
  integer put_idx;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  task automatic put(input logic [31:0] w);
    mem[put_idx] = w;
    put_idx = put_idx + 1;
  endtask

  // Branch skips one instruction when taken; bump goes into the x21 counter
  task automatic branch_pair(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [11:0] bump);
    put(enc_b(13'd8, rs2, rs1, f3));
    put(enc_i(bump, 21, 3'd0, 21, OPC_IMM));
  endtask

  initial begin
    seed = 93;
    imemory_ready = 1'b0;
    dmemory_ready = 1'b0;
    imemory_rdata = '0;
    dmemory_rdata = '0;
    i_cnt = 0;
    d_cnt = 0;
    i_wait = $unsigned($random(seed)) % 4;
    d_wait = $unsigned($random(seed)) % 4;
    for (int k = 0; k < 1024; k++) begin
      mem[k] = 32'h5A00_0000 ^ (k * 4); // Fill tied to the byte address
    end
    put_idx = 0;
    put(enc_i(12'h400, 0, 3'd0, 1, OPC_IMM)); // x1 = result base
    put(enc_u(20'h12345, 2, OPC_LUI));
    put(enc_i(12'h678, 2, 3'd0, 2, OPC_IMM));
    put(enc_s(12'h000, 2, 1, 3'd2));
    put(enc_i(12'hFFB, 0, 3'd0, 3, OPC_IMM)); // x3 = -5
    put(enc_i(12'h007, 0, 3'd0, 4, OPC_IMM)); // x4 = 7
    put(enc_r(7'h20, 3, 4, 3'd0, 5));
    put(enc_s(12'h004, 5, 1, 3'd2));
    put(enc_r(7'h00, 4, 3, 3'd2, 6));
    put(enc_r(7'h00, 4, 3, 3'd3, 7));
    put(enc_i(12'h004, 6, 3'd1, 8, OPC_IMM));
    put(enc_r(7'h00, 7, 8, 3'd6, 8));
    put(enc_s(12'h008, 8, 1, 3'd2));
    put(enc_r(7'h20, 6, 3, 3'd5, 9));
    put(enc_r(7'h00, 6, 3, 3'd5, 10));
    put(enc_r(7'h00, 10, 9, 3'd4, 11));
    put(enc_s(12'h00C, 11, 1, 3'd2));
    put(enc_i(12'h0F0, 2, 3'd7, 12, OPC_IMM));
    put(enc_i(12'hFFF, 12, 3'd4, 12, OPC_IMM));
    put(enc_s(12'h010, 12, 1, 3'd2));
    put(enc_u(20'h00001, 13, OPC_AUIPC)); // At 0x50
    put(enc_s(12'h014, 13, 1, 3'd2));
    put(enc_i(12'h000, 0, 3'd0, 21, OPC_IMM));
    branch_pair(3'd0, 4, 4, 12'd16); // Taken
    branch_pair(3'd1, 3, 4, 12'd16);
    branch_pair(3'd4, 3, 4, 12'd16);
    branch_pair(3'd5, 4, 3, 12'd16);
    branch_pair(3'd6, 4, 3, 12'd16);
    branch_pair(3'd7, 3, 4, 12'd16);
    branch_pair(3'd0, 3, 4, 12'd1); // Not taken
    branch_pair(3'd1, 4, 4, 12'd1);
    branch_pair(3'd4, 4, 3, 12'd1);
    branch_pair(3'd5, 3, 4, 12'd1);
    branch_pair(3'd6, 3, 4, 12'd1);
    branch_pair(3'd7, 4, 3, 12'd1);
    put(enc_s(12'h018, 21, 1, 3'd2));
    put(enc_j(21'd8, 22)); // At 0xC0
    put(enc_i(12'd16, 21, 3'd0, 21, OPC_IMM));
    put(enc_s(12'h01C, 22, 1, 3'd2));
    put(enc_i(12'h0D9, 0, 3'd0, 23, OPC_IMM)); // Odd target, bit 0 cleared by JALR
    put(enc_i(12'h000, 23, 3'd0, 24, OPC_JALR));
    put(enc_i(12'h000, 0, 3'd0, 24, OPC_IMM));
    put(enc_s(12'h020, 24, 1, 3'd2));
    put(enc_u(20'h8899B, 25, OPC_LUI));
    put(enc_i(12'hABB, 25, 3'd0, 25, OPC_IMM));
    put(enc_s(12'h040, 25, 1, 3'd0));
    put(enc_s(12'h041, 25, 1, 3'd0));
    put(enc_s(12'h042, 25, 1, 3'd0));
    put(enc_s(12'h043, 25, 1, 3'd0));
    put(enc_s(12'h044, 25, 1, 3'd1));
    put(enc_s(12'h046, 25, 1, 3'd1));
    put(enc_s(12'h048, 25, 1, 3'd2));
    put(enc_i(12'h049, 1, 3'd0, 26, OPC_LOAD));
    put(enc_s(12'h04C, 26, 1, 3'd2));
    put(enc_i(12'h04B, 1, 3'd4, 27, OPC_LOAD));
    put(enc_s(12'h050, 27, 1, 3'd2));
    put(enc_i(12'h04A, 1, 3'd1, 28, OPC_LOAD));
    put(enc_s(12'h054, 28, 1, 3'd2));
    put(enc_i(12'h048, 1, 3'd5, 29, OPC_LOAD));
    put(enc_s(12'h058, 29, 1, 3'd2));
    put(enc_i(12'h044, 1, 3'd2, 30, OPC_LOAD));
    put(enc_s(12'h05C, 30, 1, 3'd2));
    put(enc_j(21'd0, 0)); // Spin here
  end

  // Ready goes high for one cycle after a random number of idle cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      imemory_ready <= 1'b0;
      dmemory_ready <= 1'b0;
      i_cnt <= 0;
      d_cnt <= 0;
    end else begin
      if (imemory_ready) begin
        imemory_ready <= 1'b0;
        i_cnt <= 0;
        i_wait <= $unsigned($random(seed)) % 4;
      end else if (imemory_valid) begin
        if (i_cnt == i_wait) begin
          imemory_ready <= 1'b1;
          imemory_rdata <= mem[imemory_addr[11:2]];
        end else begin
          i_cnt <= i_cnt + 1;
        end
      end
      if (dmemory_ready) begin
        dmemory_ready <= 1'b0;
        d_cnt <= 0;
        d_wait <= $unsigned($random(seed)) % 4;
        for (int b = 0; b < 4; b++) begin
          if (dmemory_wstrb[b]) begin
            mem[dmemory_addr[11:2]][b*8 +: 8] <= dmemory_wdata[b*8 +: 8];
          end
        end
      end else if (dmemory_valid) begin
        if (d_cnt == d_wait) begin
          dmemory_ready <= 1'b1;
          dmemory_rdata <= mem[dmemory_addr[11:2]];
        end else begin
          d_cnt <= d_cnt + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int WAIT_LIMIT = 500;

  logic clk;
  logic rst_n;
  logic imemory_valid;
  logic imemory_instr;
  logic [31:0] imemory_addr;
  logic [31:0] imemory_wdata;
  logic [3:0] imemory_wstrb;
  logic [31:0] imemory_rdata;
  logic imemory_ready;
  logic dmemory_valid;
  logic dmemory_instr;
  logic [31:0] dmemory_addr;
  logic [31:0] dmemory_wdata;
  logic [3:0] dmemory_wstrb;
  logic [31:0] dmemory_rdata;
  logic dmemory_ready;

  // Expected store table
  string names[$];
  logic [31:0] exp_addr[$];
  logic [3:0] exp_strb[$];
  logic [31:0] exp_data[$];

  cpu #(
    .reset_vector (32'h0000_0000)
  ) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .imemory_valid (imemory_valid),
    .imemory_instr (imemory_instr),
    .imemory_addr  (imemory_addr),
    .imemory_wdata (imemory_wdata),
    .imemory_wstrb (imemory_wstrb),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_instr (dmemory_instr),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  mem_model mem0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timed out waiting for %s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic add_store(input string name, input logic [31:0] addr,
                           input logic [3:0] strb, input logic [31:0] data);
    names.push_back(name);
    exp_addr.push_back(addr);
    exp_strb.push_back(strb);
    exp_data.push_back(data);
  endtask

  initial begin
    int cnt;
    rst_n = 1'b0;
    add_store("lui_addi", 32'h400, 4'hF, 32'h1234_5678);
    add_store("sub", 32'h404, 4'hF, 32'h0000_000C);
    add_store("slt_sltu", 32'h408, 4'hF, 32'h0000_0010);
    add_store("shift_xor", 32'h40C, 4'hF, 32'h8000_0000);
    add_store("andi_xori", 32'h410, 4'hF, 32'hFFFF_FF8F);
    add_store("auipc", 32'h414, 4'hF, 32'h0000_1050);
    add_store("branches", 32'h418, 4'hF, 32'h0000_0006);
    add_store("jal_link", 32'h41C, 4'hF, 32'h0000_00C4);
    add_store("jalr_link", 32'h420, 4'hF, 32'h0000_00D4);
    add_store("sb_off0", 32'h440, 4'h1, 32'hBBBB_BBBB);
    add_store("sb_off1", 32'h440, 4'h2, 32'hBBBB_BBBB);
    add_store("sb_off2", 32'h440, 4'h4, 32'hBBBB_BBBB);
    add_store("sb_off3", 32'h440, 4'h8, 32'hBBBB_BBBB);
    add_store("sh_off0", 32'h444, 4'h3, 32'hAABB_AABB);
    add_store("sh_off2", 32'h444, 4'hC, 32'hAABB_AABB);
    add_store("sw", 32'h448, 4'hF, 32'h8899_AABB);
    add_store("lb", 32'h44C, 4'hF, 32'hFFFF_FFAA);
    add_store("lbu", 32'h450, 4'hF, 32'h0000_0088);
    add_store("lh", 32'h454, 4'hF, 32'hFFFF_8899);
    add_store("lhu", 32'h458, 4'hF, 32'h0000_AABB);
    add_store("lw", 32'h45C, 4'hF, 32'hAABB_AABB);

    // Five reset edges, then the first cycle out of reset
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (i == 4) begin
        rst_n <= 1'b1;
      end
      @(negedge clk);
      check("reset_ivalid", 32'd0, imemory_valid);
      check("reset_dvalid", 32'd0, dmemory_valid);
    end

    cnt = 0;
    while (!imemory_valid) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        timed_out("the first instruction fetch");
      end
    end
    check("first_fetch_addr", 32'h0000_0000, imemory_addr);
    check("first_fetch_instr", 32'd1, imemory_instr);
    check("first_fetch_strb", 32'd0, imemory_wstrb);
    check("first_fetch_wdata", 32'd0, imemory_wdata);

    foreach (names[k]) begin
      cnt = 0;
      do begin
        @(negedge clk);
        cnt++;
        if (cnt > WAIT_LIMIT) begin
          timed_out($sformatf("store %s", names[k]));
        end
        if (imemory_valid) begin
          check("fetch_addr_align", 32'd0, imemory_addr[1:0]); // Catches an odd JALR target
          check("fetch_instr", 32'd1, imemory_instr);
          check("fetch_strb", 32'd0, imemory_wstrb);
        end
      end while (!(dmemory_valid && dmemory_ready && dmemory_wstrb != 4'b0000));
      check({names[k], " addr"}, exp_addr[k], dmemory_addr);
      check({names[k], " strb"}, exp_strb[k], dmemory_wstrb);
      check({names[k], " data"}, exp_data[k], dmemory_wdata);
      check({names[k], " instr"}, 32'd0, dmemory_instr);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/riscv_pkg.sv
src/mem_pkg.sv
src/mem_if.sv
src/fetch_unit.sv
src/execute_unit.sv
src/register_file.sv
src/lsu.sv
src/cpu.sv
tests/mem_model.sv
tests/cpu_tb.sv
